/* design/sgd_defines.svh */
`ifndef SGD_DEFINES_SVH
`define SGD_DEFINES_SVH

// feature lanes, also the width of one bit-plane word
`define SGD_DIM 8

// arithmetic word for x, dot, error and gradient
`define SGD_WORD 32

// upper bound on bit planes per sample
`define SGD_BITS_MAX 8

`define SGD_PARAM_W 512

// plane input fifo and plane buffer share this depth
`define SGD_A_FIFO_DEPTH_BITS 5
`define SGD_B_FIFO_DEPTH_BITS 3

// free slots left when almost_full rises
`define SGD_AF_MARGIN 4

`endif

/* design/sgd_pkg.sv */
`include "sgd_defines.svh"

package sgd_pkg;

    typedef logic signed [`SGD_WORD-1:0] sgd_word_t;

    // host parameter word, MSB first
    typedef struct packed {
        logic [127:0] rsvd_hi;
        logic [31:0]  number_of_bits;      // 383:352
        logic [31:0]  number_of_samples;   // 351:320
        logic [63:0]  rsvd_mid;            // epochs and dimension, unused here
        logic [31:0]  step_size;           // 255:224, shift count in [4:0]
        logic [31:0]  mini_batch_size;     // 223:192
        logic [191:0] rsvd_lo;             // host addresses
    } sgd_params_t;

    // raw word on the port, decoded through f
    typedef union packed {
        logic [`SGD_PARAM_W-1:0] raw;
        sgd_params_t             f;
    } sgd_params_u;

endpackage

/* design/sgd_ctrl.sv */
`timescale 1ns/10ps

module sgd_ctrl import sgd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_g,
    input  logic        start,
    input  sgd_params_u params,
    input  logic        wb_done,
    output logic        started,
    output logic [31:0] mini_batch_size,
    output logic [4:0]  step_shift,
    output logic [31:0] number_of_samples,
    output logic [31:0] number_of_bits,
    output logic        done
);

    logic armed;   // start taken, started follows
    logic take;

    assign take = start & ~armed;

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            armed   <= 1'b0;
            started <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            if (take)
                armed <= 1'b1;
            started <= armed;     // params settled one cycle before
            if (wb_done)
                done <= 1'b1;     // held until reset
        end
    end

    //////////////////////////////
    // parameter decode
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            mini_batch_size   <= params.f.mini_batch_size;
            step_shift        <= params.f.step_size[4:0];
            number_of_samples <= params.f.number_of_samples;
            number_of_bits    <= params.f.number_of_bits;
        end
    end

endmodule

/* design/sgd_dot_product.sv */
`timescale 1ns/10ps
`include "sgd_defines.svh"

module sgd_dot_product import sgd_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n_g,
    input  logic                     started,
    input  logic [31:0]              number_of_bits,
    input  logic [31:0]              mini_batch_size,
    input  logic [31:0]              number_of_samples,
    input  logic [`SGD_DIM-1:0]      a_data,
    input  logic                     a_wr_en,
    output logic                     a_almost_full,
    input  sgd_word_t [`SGD_DIM-1:0] x,
    input  logic                     x_updated,
    input  logic                     loss_busy,
    input  logic                     plane_rd_en,
    output logic [`SGD_DIM-1:0]      plane_rd_data,
    output sgd_word_t                dot,
    output logic                     dot_valid,
    output logic                     sample_last,
    output logic                     batch_last
);

    // plane input fifo
    logic [`SGD_DIM-1:0]               in_mem [2**`SGD_A_FIFO_DEPTH_BITS];
    logic [`SGD_A_FIFO_DEPTH_BITS-1:0] in_wp;
    logic [`SGD_A_FIFO_DEPTH_BITS-1:0] in_rp;
    logic [`SGD_A_FIFO_DEPTH_BITS:0]   in_cnt;
    // plane buffer, read back by the gradient
    logic [`SGD_DIM-1:0]               pb_mem [2**`SGD_A_FIFO_DEPTH_BITS];
    logic [`SGD_A_FIFO_DEPTH_BITS-1:0] pb_wp;
    logic [`SGD_A_FIFO_DEPTH_BITS-1:0] pb_rp;
    logic [`SGD_A_FIFO_DEPTH_BITS:0]   pb_cnt;
    logic [`SGD_A_FIFO_DEPTH_BITS+1:0] fill;

    logic [$clog2(`SGD_BITS_MAX):0]    bit_cnt;
    logic [$clog2(`SGD_BITS_MAX):0]    nb_m1;
    logic [31:0]                       sample_cnt;
    logic [31:0]                       batch_pos;
    logic                              x_wait;      // batch closed, x not yet updated
    logic [`SGD_DIM-1:0]               plane;
    logic                              first;
    logic                              last;
    logic                              pb_ok;
    logic                              is_run_last;
    logic                              is_batch_last;
    logic                              consume;
    sgd_word_t                         psum;
    sgd_word_t                         acc_next;

    assign plane         = in_mem[in_rp];
    assign plane_rd_data = pb_mem[pb_rp];

    // almost_full covers both fifos
    assign fill          = {1'b0, in_cnt} + {1'b0, pb_cnt};
    assign a_almost_full = fill >= (2**`SGD_A_FIFO_DEPTH_BITS - `SGD_AF_MARGIN);

    assign nb_m1         = number_of_bits[$clog2(`SGD_BITS_MAX):0] - 1'b1;
    assign first         = bit_cnt == '0;
    assign last          = bit_cnt == nb_m1;
    assign pb_ok         = pb_cnt <= number_of_bits[`SGD_A_FIFO_DEPTH_BITS:0]; // one sample queued at most
    assign is_run_last   = sample_cnt == number_of_samples - 1'b1;
    assign is_batch_last = (batch_pos == mini_batch_size - 1'b1) | is_run_last;

    assign consume = started & (in_cnt != '0) & ~loss_busy
                   & (sample_cnt != number_of_samples)
                   & (~first | (~x_wait & pb_ok));

    // sum of x over the set bits of this plane
    always_comb
    begin
        psum = '0;
        for (int f = 0; f < `SGD_DIM; f++)
        begin
            if (plane[f])
                psum = psum + x[f];
        end
    end

    assign acc_next = (first ? sgd_word_t'(0) : dot <<< 1) + psum;

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            in_wp      <= '0;
            in_rp      <= '0;
            in_cnt     <= '0;
            pb_wp      <= '0;
            pb_rp      <= '0;
            pb_cnt     <= '0;
            bit_cnt    <= '0;
            sample_cnt <= '0;
            batch_pos  <= '0;
            x_wait     <= 1'b0;
            dot_valid  <= 1'b0;
        end
        else
        begin
            if (a_wr_en)
                in_wp <= in_wp + 1'b1;
            if (a_wr_en & ~consume)
                in_cnt <= in_cnt + 1'b1;
            else if (~a_wr_en & consume)
                in_cnt <= in_cnt - 1'b1;

            if (plane_rd_en)
                pb_rp <= pb_rp + 1'b1;
            if (consume & ~plane_rd_en)
                pb_cnt <= pb_cnt + 1'b1;
            else if (~consume & plane_rd_en)
                pb_cnt <= pb_cnt - 1'b1;

            dot_valid <= consume & last;
            if (consume)
            begin
                in_rp   <= in_rp + 1'b1;
                pb_wp   <= pb_wp + 1'b1;
                bit_cnt <= last ? '0 : bit_cnt + 1'b1;
                if (last)
                begin
                    sample_cnt <= sample_cnt + 1'b1;
                    batch_pos  <= is_batch_last ? '0 : batch_pos + 1'b1;
                end
            end

            if (consume & last & is_batch_last & ~is_run_last)
                x_wait <= 1'b1;
            else if (x_updated)
                x_wait <= 1'b0;
        end
    end

    // dot doubles as the accumulator
    always_ff @(posedge clk)
    begin
        if (a_wr_en)
            in_mem[in_wp] <= a_data;
        if (consume)
        begin
            pb_mem[pb_wp] <= plane;
            dot           <= acc_next;
            sample_last   <= is_run_last;
            batch_last    <= is_batch_last;
        end
    end

endmodule

/* design/sgd_serial_loss.sv */
`timescale 1ns/10ps
`include "sgd_defines.svh"

module sgd_serial_loss import sgd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_g,
    input  logic [4:0] step_shift,
    input  sgd_word_t  b_data,
    input  logic       b_wr_en,
    output logic       b_almost_full,
    input  sgd_word_t  dot,
    input  logic       dot_valid,
    input  logic       sample_last,
    input  logic       batch_last,
    output logic       loss_busy,
    output sgd_word_t  err,
    output logic       err_valid,
    output logic       err_batch_last,
    output logic       err_run_last
);

    // label fifo
    sgd_word_t                         b_mem [2**`SGD_B_FIFO_DEPTH_BITS];
    logic [`SGD_B_FIFO_DEPTH_BITS-1:0] b_wp;
    logic [`SGD_B_FIFO_DEPTH_BITS-1:0] b_rp;
    logic [`SGD_B_FIFO_DEPTH_BITS:0]   b_cnt;

    logic      held;       // dot waiting for its label
    logic      fire;
    sgd_word_t diff;

    assign b_almost_full = b_cnt >= (2**`SGD_B_FIFO_DEPTH_BITS - `SGD_AF_MARGIN);
    assign loss_busy     = held | dot_valid;

    // dot and its flags stay frozen upstream while loss_busy
    assign fire    = loss_busy & (b_cnt != '0);
    assign diff    = dot - b_mem[b_rp];

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            b_wp      <= '0;
            b_rp      <= '0;
            b_cnt     <= '0;
            held      <= 1'b0;
            err_valid <= 1'b0;
        end
        else
        begin
            if (b_wr_en)
                b_wp <= b_wp + 1'b1;
            if (fire)
                b_rp <= b_rp + 1'b1;
            if (b_wr_en & ~fire)
                b_cnt <= b_cnt + 1'b1;
            else if (~b_wr_en & fire)
                b_cnt <= b_cnt - 1'b1;
            held      <= loss_busy & ~fire;
            err_valid <= fire;
        end
    end

    always_ff @(posedge clk)
    begin
        if (b_wr_en)
            b_mem[b_wp] <= b_data;
        if (fire)
        begin
            err            <= diff >>> step_shift;   // scaled by the step size
            err_batch_last <= batch_last;
            err_run_last   <= sample_last;
        end
    end

endmodule

/* design/sgd_gradient.sv */
`timescale 1ns/10ps
`include "sgd_defines.svh"

module sgd_gradient import sgd_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n_g,
    input  logic [31:0]              number_of_bits,
    input  sgd_word_t                err,
    input  logic                     err_valid,
    input  logic                     err_batch_last,
    input  logic                     err_run_last,
    output logic                     plane_rd_en,
    input  logic [`SGD_DIM-1:0]      plane_rd_data,
    output sgd_word_t [`SGD_DIM-1:0] grad,
    output logic                     grad_valid,
    output logic                     run_last
);

    logic                           active;
    logic [$clog2(`SGD_BITS_MAX):0] bit_cnt;
    logic [$clog2(`SGD_BITS_MAX):0] nb_m1;
    logic                           finish;
    logic                           load;
    sgd_word_t                      err_sh;

    // sample being accumulated
    sgd_word_t cur_err;
    logic      cur_bl;
    logic      cur_rl;
    // one error queued behind it
    logic      pend_v;
    sgd_word_t pend_err;
    logic      pend_bl;
    logic      pend_rl;

    assign nb_m1       = number_of_bits[$clog2(`SGD_BITS_MAX):0] - 1'b1;
    assign finish      = active & (bit_cnt == nb_m1);
    assign load        = ~active | finish;
    assign plane_rd_en = active;
    assign err_sh      = cur_err <<< (nb_m1 - bit_cnt);   // weight of this plane, msb first

    //////////////////////////////
    // accumulate, clear after hand-off
    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            active     <= 1'b0;
            pend_v     <= 1'b0;
            bit_cnt    <= '0;
            grad_valid <= 1'b0;
            run_last   <= 1'b0;
            grad       <= '0;
        end
        else
        begin
            grad_valid <= finish & cur_bl;
            run_last   <= finish & cur_rl;
            for (int f = 0; f < `SGD_DIM; f++)
            begin
                grad[f] <= (grad_valid ? sgd_word_t'(0) : grad[f])
                         + ((active & plane_rd_data[f]) ? err_sh : sgd_word_t'(0));
            end
            if (load)
            begin
                bit_cnt <= '0;
                active  <= pend_v | err_valid;
                pend_v  <= pend_v & err_valid;
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (err_valid)
                    pend_v <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (err_valid)
        begin
            pend_err <= err;
            pend_bl  <= err_batch_last;
            pend_rl  <= err_run_last;
        end
        if (load)
        begin
            cur_err <= pend_v ? pend_err : err;
            cur_bl  <= pend_v ? pend_bl : err_batch_last;
            cur_rl  <= pend_v ? pend_rl : err_run_last;
        end
    end

endmodule

/* design/sgd_x_model.sv */
`timescale 1ns/10ps
`include "sgd_defines.svh"

module sgd_x_model import sgd_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n_g,
    input  logic                     started,
    input  sgd_word_t [`SGD_DIM-1:0] grad,
    input  logic                     grad_valid,
    input  logic                     run_last,
    input  logic                     model_almost_full,
    output sgd_word_t [`SGD_DIM-1:0] x,
    output logic                     x_updated,
    output sgd_word_t                model_data,
    output logic                     model_valid,
    output logic                     wb_done
);

    logic                         wb_active;
    logic [$clog2(`SGD_DIM)-1:0]  wb_idx;
    logic                         wb_last;

    //////////////////////////////
    // write-back stream
    assign model_valid = wb_active & ~model_almost_full;  // no word while sink is full
    assign model_data  = x[wb_idx];
    assign wb_last     = wb_idx == `SGD_DIM - 1;
    assign wb_done     = model_valid & wb_last;

    always_ff @(posedge clk)
    begin
        if (!rst_n_g)
        begin
            x_updated <= 1'b0;
            wb_active <= 1'b0;
            wb_idx    <= '0;
        end
        else
        begin
            x_updated <= grad_valid;
            if (grad_valid & run_last)
                wb_active <= 1'b1;        // final batch applied
            else if (wb_done)
                wb_active <= 1'b0;
            if (model_valid)
                wb_idx <= wb_last ? '0 : wb_idx + 1'b1;
        end
    end

    //////////////////////////////
    // model registers
    always_ff @(posedge clk)
    begin
        for (int f = 0; f < `SGD_DIM; f++)
        begin
            if (!started)
                x[f] <= '0;               // every run starts from zero
            else if (grad_valid)
                x[f] <= x[f] - grad[f];
        end
    end

endmodule

/* design/sgd_top.sv */
`timescale 1ns/10ps
`include "sgd_defines.svh"

module sgd_top import sgd_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_g,
    input  logic                start,
    input  sgd_params_u         params,
    input  logic [`SGD_DIM-1:0] a_data,
    input  logic                a_wr_en,
    output logic                a_almost_full,
    input  sgd_word_t           b_data,
    input  logic                b_wr_en,
    output logic                b_almost_full,
    output sgd_word_t           model_data,
    output logic                model_valid,
    input  logic                model_almost_full,
    output logic                done
);

    // latched run parameters
    logic                     started;
    logic [31:0]              mini_batch_size;
    logic [4:0]               step_shift;
    logic [31:0]              number_of_samples;
    logic [31:0]              number_of_bits;

    // dot product -> loss
    sgd_word_t                dot;
    logic                     dot_valid;
    logic                     sample_last;
    logic                     batch_last;
    logic                     loss_busy;

    // loss -> gradient
    sgd_word_t                err;
    logic                     err_valid;
    logic                     err_batch_last;
    logic                     err_run_last;
    logic                     plane_rd_en;
    logic [`SGD_DIM-1:0]      plane_rd_data;

    // gradient <-> model
    sgd_word_t [`SGD_DIM-1:0] grad;
    logic                     grad_valid;
    logic                     run_last;
    sgd_word_t [`SGD_DIM-1:0] x;
    logic                     x_updated;
    logic                     wb_done;

    sgd_ctrl        inst_ctrl        (.*);
    sgd_dot_product inst_dot_product (.*);
    sgd_serial_loss inst_serial_loss (.*);
    sgd_gradient    inst_gradient    (.*);
    sgd_x_model     inst_x_model     (.*);

endmodule

/* bench/tb_sgd.sv */
`timescale 1ns/10ps
`include "sgd_defines.svh"

module tb_sgd import sgd_pkg::*;
();

    localparam int MAX_SAMPLES = 16;
    localparam int RUN_LIMIT   = 4000;   // cycles per run

    logic                clk;
    logic                rst_n_g;
    logic                start;
    sgd_params_u         params;
    logic [`SGD_DIM-1:0] a_data;
    logic                a_wr_en;
    logic                a_almost_full;
    sgd_word_t           b_data;
    logic                b_wr_en;
    logic                b_almost_full;
    sgd_word_t           model_data;
    logic                model_valid;
    logic                model_almost_full;
    logic                done;

    integer seed;
    int     errors;
    int     n_pass;
    int     n_fail;
    bit     timed_out;

    // stimulus and reference model
    logic [`SGD_BITS_MAX-1:0] a_val [MAX_SAMPLES][`SGD_DIM];
    sgd_word_t                b_val [MAX_SAMPLES];
    sgd_word_t                x_ref [`SGD_DIM];

    sgd_top dut0
    (
        .clk               (clk),
        .rst_n_g           (rst_n_g),
        .start             (start),
        .params            (params),
        .a_data            (a_data),
        .a_wr_en           (a_wr_en),
        .a_almost_full     (a_almost_full),
        .b_data            (b_data),
        .b_wr_en           (b_wr_en),
        .b_almost_full     (b_almost_full),
        .model_data        (model_data),
        .model_valid       (model_valid),
        .model_almost_full (model_almost_full),
        .done              (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // stimulus and model

    // fields at host positions, reserved bits all ones
    function automatic logic [`SGD_PARAM_W-1:0] param_word(input int mbs, input int ns,
                                                           input int nb, input int sh);
        logic [`SGD_PARAM_W-1:0] w;
        w          = '1;
        w[223:192] = mbs;
        w[255:224] = 32'hffff_ffe0 | sh;   // upper step bits ignored
        w[351:320] = ns;
        w[383:352] = nb;
        return w;
    endfunction

    task automatic make_data(input int ns, input int nb);
        logic [31:0] r;
        int          s;
        int          f;
        for (s = 0; s < ns; s++)
        begin
            for (f = 0; f < `SGD_DIM; f++)
            begin
                r           = $random(seed);
                a_val[s][f] = r[`SGD_BITS_MAX-1:0] & ((1 << nb) - 1);
            end
            b_val[s] = $random(seed);
        end
    endtask

    task automatic build_model(input int ns, input int mbs, input int nb, input int sh);
        sgd_word_t g [`SGD_DIM];
        sgd_word_t acc;
        sgd_word_t err;
        sgd_word_t av;
        int        s;
        int        p;
        int        f;
        int        pos;
        for (f = 0; f < `SGD_DIM; f++)
        begin
            x_ref[f] = '0;
            g[f]     = '0;
        end
        pos = 0;
        for (s = 0; s < ns; s++)
        begin
            acc = '0;
            for (p = nb - 1; p >= 0; p--)   // msb plane first
            begin
                acc = acc * 2;
                for (f = 0; f < `SGD_DIM; f++)
                begin
                    if (a_val[s][f][p])
                        acc = acc + x_ref[f];
                end
            end
            err = (acc - b_val[s]) >>> sh;
            for (f = 0; f < `SGD_DIM; f++)
            begin
                av   = sgd_word_t'(a_val[s][f]);
                g[f] = g[f] + err * av;
            end
            pos++;
            if (pos == mbs || s == ns - 1)   // batch boundary, short last batch too
            begin
                for (f = 0; f < `SGD_DIM; f++)
                begin
                    x_ref[f] = x_ref[f] - g[f];
                    g[f]     = '0;
                end
                pos = 0;
            end
        end
    endtask

    task automatic apply_reset();
        int i;
        rst_n_g           = 1'b0;
        start             = 1'b0;
        params.raw        = '0;
        a_data            = '0;
        a_wr_en           = 1'b0;
        b_data            = '0;
        b_wr_en           = 1'b0;
        model_almost_full = 1'b0;
        for (i = 0; i < 10; i++)
            @(posedge clk);
        #2;
        rst_n_g = 1'b1;
    endtask

    task automatic compare_word(input string what, input sgd_word_t expected,
                                input sgd_word_t actual);
        assert (actual === expected)
        else
        begin
            $display("[ERROR] %s: expected %0d, actual %0d", what, expected, actual);
            errors++;
        end
    endtask

    //////////////////////////////
    // one full run from reset to done
    task automatic run_test(input string name, input int ns, input int mbs, input int nb,
                            input int sh, input bit hold_labels, input bit out_bp,
                            input bit restart);
        logic [31:0] r;
        int          errs_at_start;
        int          a_idx;
        int          b_idx;
        int          beats;
        int          cyc;
        int          s;
        int          p;
        int          f;
        int          i;
        bit          saw_full;
        errs_at_start = errors;
        a_idx         = 0;
        b_idx         = 0;
        beats         = 0;
        saw_full      = 1'b0;
        make_data(ns, nb);
        build_model(ns, mbs, nb, sh);
        apply_reset();

        for (i = 0; i < 3; i++)
        begin
            @(negedge clk);
            assert (!done && !model_valid)
            else
            begin
                $display("%s: done or model_valid high after reset", name);
                errors++;
            end
        end
        @(posedge clk);
        #2;
        params.raw = param_word(mbs, ns, nb, sh);

        cyc = 0;
        while (!done && cyc < RUN_LIMIT)
        begin
            if (a_idx < ns * nb && !a_almost_full)
            begin
                s = a_idx / nb;
                p = nb - 1 - a_idx % nb;
                for (f = 0; f < `SGD_DIM; f++)
                    a_data[f] = a_val[s][f][p];
                a_wr_en = 1'b1;
                a_idx++;
            end
            else
                a_wr_en = 1'b0;
            // labels held back until the plane fifo fills or all planes are in
            if (b_idx < ns && !b_almost_full
                && (!hold_labels || saw_full || a_idx == ns * nb))
            begin
                b_data  = b_val[b_idx];
                b_wr_en = 1'b1;
                b_idx++;
            end
            else
                b_wr_en = 1'b0;
            r                 = $random(seed);
            model_almost_full = out_bp & r[0];
            if (restart && cyc == 10)
                params.raw = param_word(1, 2, 3, 7);   // must be ignored
            start = (cyc == 0) || (restart && cyc >= 10 && cyc < 14);

            @(negedge clk);
            if (a_almost_full)
                saw_full = 1'b1;
            if (model_valid)
            begin
                assert (!model_almost_full)
                else
                begin
                    $display("%s: model_valid while model_almost_full was high", name);
                    errors++;
                end
                if (beats < `SGD_DIM)
                    compare_word($sformatf("%s x[%0d]", name, beats), x_ref[beats], model_data);
                beats++;
            end
            @(posedge clk);
            #2;
            cyc++;
        end
        a_wr_en           = 1'b0;
        b_wr_en           = 1'b0;
        start             = 1'b0;
        model_almost_full = 1'b0;

        if (!done)
        begin
            $display("%s: timeout, done did not rise within %0d cycles", name, RUN_LIMIT);
            timed_out = 1'b1;
        end
        else
        begin
            for (i = 0; i < 6; i++)   // nothing more after done
            begin
                @(negedge clk);
                if (model_valid)
                    beats++;
            end
            assert (beats == `SGD_DIM)
            else
            begin
                $display("[ERROR] %s beats: expected %0d, actual %0d", name, `SGD_DIM, beats);
                errors++;
            end
            if (hold_labels)
            begin
                assert (saw_full)
                else
                begin
                    $display("%s: a_almost_full never rose during the burst", name);
                    errors++;
                end
            end
        end

        if (errors == errs_at_start && !timed_out)
        begin
            $display("%-20s passed", name);
            n_pass++;
        end
        else
        begin
            $display("%-20s failed", name);
            n_fail++;
        end
    endtask

    initial
    begin
        seed      = 97135;
        errors    = 0;
        n_pass    = 0;
        n_fail    = 0;
        timed_out = 1'b0;

        run_test("single_sample", 1, 1, 8, 0, 1'b0, 1'b0, 1'b0);
        if (!timed_out)
            run_test("random_batches", 12, 4, 6, 3, 1'b0, 1'b0, 1'b0);
        if (!timed_out)
            run_test("short_last_batch", 10, 4, 5, 2, 1'b0, 1'b0, 1'b0);
        if (!timed_out)
            run_test("input_backpressure", 12, 3, 8, 1, 1'b1, 1'b0, 1'b0);
        if (!timed_out)
            run_test("output_backpressure", 8, 2, 7, 4, 1'b0, 1'b1, 1'b0);
        if (!timed_out)
            run_test("control_restart", 6, 2, 4, 0, 1'b0, 1'b0, 1'b1);

        $display("tests passed: %0d, failed: %0d, errors: %0d", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0 && !timed_out)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* list.f */
+incdir+design
design/sgd_pkg.sv
design/sgd_ctrl.sv
design/sgd_dot_product.sv
design/sgd_serial_loss.sv
design/sgd_gradient.sv
design/sgd_x_model.sv
design/sgd_top.sv
bench/tb_sgd.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the sgd testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_sgd -o tb_sgd_sim

./obj_dir/tb_sgd_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi

grep -q "TEST PASS" sim.log
echo "simulation passed"
